//--- Makefile
# Verilator build and run of the Ethernet statistics collector testbench

VERILATOR ?= verilator
TOP       ?= eth_stats_tb
FILELIST  ?= compile.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing
SRCS      ?= $(wildcard hw/*.sv dv/*.sv)

SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

# The log decides the result, the simulator exit code alone is not trusted
run: compile
	./$(SIM_BIN) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "^STATUS: PASS$$" $(LOG); then \
		echo "Simulation passed"; \
	else \
		echo "Simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- compile.f
hw/eth_stats_pkg.sv
hw/eth_stats_adder.sv
hw/eth_stats_snapshot.sv
hw/eth_stats_regs.sv
hw/eth_stats_collector.sv
dv/eth_stats_tb.sv

//--- dv/eth_stats_tb.sv
// ######################################
// Ethernet statistics collector testbench
// Directed tests of counting, gating, hold
// snapshot and software reset via the host
// ######################################

`timescale 1ns/1ps

module eth_stats_tb;
	import eth_stats_pkg::*;

	logic                clk;
	logic                rst_n;
	logic                wr_en;
	logic                rd_en;
	logic [ADDR_W-1:0]   addr;
	logic [DATA_W-1:0]   wr_data;
	logic [DATA_W-1:0]   rd_data;
	logic                rd_valid;
	tx_stats_t           tx_stats_vector;
	logic                tx_stats_valid;
	rx_stats_t           rx_stats_vector;
	logic                rx_stats_valid;
	logic [63:0]         current_time;
	logic                time_running;

	// Reference model state
	cfg_t                exp_cfg;
	stats_totals_t       exp_tx;
	stats_totals_t       exp_rx;
	logic [63:0]         exp_time;
	logic [31:0]         lfsr_state;
	int                  errors;
	int                  checks;

	eth_stats_collector i_eth_stats_collector (
		.clk             (clk),
		.rst_n           (rst_n),
		.wr_en           (wr_en),
		.rd_en           (rd_en),
		.addr            (addr),
		.wr_data         (wr_data),
		.rd_data         (rd_data),
		.rd_valid        (rd_valid),
		.tx_stats_vector (tx_stats_vector),
		.tx_stats_valid  (tx_stats_valid),
		.rx_stats_vector (rx_stats_vector),
		.rx_stats_valid  (rx_stats_valid),
		.current_time    (current_time),
		.time_running    (time_running)
	);

	// 40 ns clock
	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	// Reference timer steps once per cycle at the same drive point as all inputs
	initial begin
		forever begin
			@(posedge clk);
			#2;
			current_time = current_time + 64'd1;
		end
	end

	// Galois LFSR stepped once for every bit handed out
	function automatic logic [31:0] next_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ 32'h80200003)
				: (lfsr_state >> 1);
			v = {v[30:0], lfsr_state[0]};
		end
		return v;
	endfunction

	// Model of one counted frame where the length always adds and bit 0 picks good or bad
	function automatic stats_totals_t add_frame(input stats_totals_t t, input logic [13:0] len,
			input logic good);
		stats_totals_t r;
		r = t;
		r.bytes = r.bytes + 64'(len);
		if (good) begin
			r.good = r.good + 64'd1;
		end else begin
			r.bad = r.bad + 64'd1;
		end
		return r;
	endfunction

	// Closing summary and end of the run
	task automatic finish_run();
		$display("Checks run: %0d, errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("STATUS: PASS");
		end else begin
			$display("STATUS: FAIL");
		end
		$finish;
	endtask

	// All tasks start and end on a drive point 2 ns after a rising edge
	task automatic idle(input int n);
		repeat (n) begin
			@(posedge clk);
			#2;
		end
	endtask

	task automatic write_reg(input logic [ADDR_W-1:0] a, input logic [DATA_W-1:0] d);
		wr_en = 1'b1;
		addr = a;
		wr_data = d;
		@(posedge clk);
		#2;
		wr_en = 1'b0;
	endtask

	// Writes the configuration and keeps the model in step
	task automatic write_cfg(input cfg_t c);
		write_reg(REG_CFG, DATA_W'(c));
		exp_cfg = c;
	endtask

	// The answer has to come within 20 cycles and last exactly one cycle
	task automatic read_reg(input logic [ADDR_W-1:0] a, output logic [DATA_W-1:0] d,
			output logic ok);
		int waited;
		rd_en = 1'b1;
		addr = a;
		@(posedge clk);
		#2;
		rd_en = 1'b0;
		waited = 0;
		while (rd_valid !== 1'b1 && waited < 20) begin
			@(posedge clk);
			#2;
			waited++;
		end
		ok = (rd_valid === 1'b1);
		d = rd_data;
		if (!ok) begin
			$display("Error: no read response for address %h within 20 cycles", a);
			errors++;
		end else begin
			@(posedge clk);
			#2;
			if (rd_valid !== 1'b0) begin
				errors++;
				$display("Mismatch rd_valid: got %h expected %h", rd_valid, 1'b0);
			end
		end
	endtask

	task automatic check_reg(input string name, input logic [ADDR_W-1:0] a,
			input logic [DATA_W-1:0] exp);
		logic [DATA_W-1:0] got;
		logic              ok;
		read_reg(a, got, ok);
		checks++;
		if (ok && got !== exp) begin
			errors++;
			$display("Mismatch %s: got %h expected %h", name, got, exp);
		end
	endtask

	// A 64-bit value sits at two offsets with the low word first
	task automatic check_pair(input string name, input logic [ADDR_W-1:0] a,
			input logic [63:0] v);
		check_reg({name, "_L"}, a, v[31:0]);
		check_reg({name, "_H"}, a + 8'h04, v[63:32]);
	endtask

	task automatic check_view(input logic [63:0] t, input stats_totals_t tx,
			input stats_totals_t rx);
		check_reg("CFG", REG_CFG, DATA_W'(exp_cfg));
		check_pair("TIME", REG_TIME_L, t);
		check_pair("TX_BYTES", REG_TX_BYTES_L, tx.bytes);
		check_pair("TX_GOOD", REG_TX_GOOD_L, tx.good);
		check_pair("TX_BAD", REG_TX_BAD_L, tx.bad);
		check_pair("RX_BYTES", REG_RX_BYTES_L, rx.bytes);
		check_pair("RX_GOOD", REG_RX_GOOD_L, rx.good);
		check_pair("RX_BAD", REG_RX_BAD_L, rx.bad);
	endtask

	// One frame is valid for one cycle and has every reserved bit set so the DUT must ignore it
	task automatic send_frame(input logic is_rx, input logic [13:0] len, input logic good);
		logic counted;
		counted = exp_cfg.enable && !exp_cfg.srst && time_running;
		if (is_rx) begin
			rx_stats_vector = '1;
			rx_stats_vector.frame_length = len;
			rx_stats_vector.frame_good = good;
			rx_stats_valid = 1'b1;
		end else begin
			tx_stats_vector = '1;
			tx_stats_vector.frame_length = len;
			tx_stats_vector.frame_good = good;
			tx_stats_valid = 1'b1;
		end
		@(posedge clk);
		// The timer still holds the value the DUT samples on this edge
		if (counted) begin
			if (is_rx) begin
				exp_rx = add_frame(exp_rx, len, good);
			end else begin
				exp_tx = add_frame(exp_tx, len, good);
			end
			exp_time = current_time;
		end
		#2;
		tx_stats_valid = 1'b0;
		rx_stats_valid = 1'b0;
	endtask

	// Random frames with a random gap of zero or one cycle after each
	task automatic run_frames(input logic is_rx, input int n);
		for (int i = 0; i < n; i++) begin
			send_frame(is_rx, 14'(next_bits(14)), 1'(next_bits(1)));
			if (next_bits(1) == 32'd1) begin
				idle(1);
			end
		end
		// The view takes one more edge to follow the counters
		idle(1);
	endtask

	task automatic test_reset_values();
		// No read answer may be pending straight out of reset
		checks++;
		if (rd_valid !== 1'b0) begin
			errors++;
			$display("Mismatch rd_valid: got %h expected %h", rd_valid, 1'b0);
		end
		check_view(64'd0, '0, '0);
		check_reg("RSVD_04", 8'h04, 32'd0);
		check_reg("RSVD_08", 8'h08, 32'd0);
		check_reg("RSVD_0C", 8'h0C, 32'd0);
		check_reg("RSVD_48", 8'h48, 32'd0);
		check_reg("RSVD_FC", 8'hFC, 32'd0);
		// Counter offsets are read only
		write_reg(REG_TX_BYTES_L, 32'hffff_ffff);
		check_view(64'd0, '0, '0);
	endtask

	task automatic test_tx_counting();
		write_cfg(3'b001);
		run_frames(1'b0, 24);
		check_view(exp_time, exp_tx, exp_rx);
	endtask

	task automatic test_rx_counting();
		run_frames(1'b1, 24);
		check_view(exp_time, exp_tx, exp_rx);
	endtask

	// Neither a disabled collector nor a stopped timer may count
	task automatic test_gated_frames();
		write_cfg(3'b000);
		run_frames(1'b0, 6);
		run_frames(1'b1, 6);
		check_view(exp_time, exp_tx, exp_rx);
		write_cfg(3'b001);
		time_running = 1'b0;
		run_frames(1'b0, 6);
		run_frames(1'b1, 6);
		check_view(exp_time, exp_tx, exp_rx);
		time_running = 1'b1;
	endtask

	task automatic test_hold_snapshot();
		stats_totals_t held_tx;
		stats_totals_t held_rx;
		logic [63:0]   held_time;
		held_tx = exp_tx;
		held_rx = exp_rx;
		held_time = exp_time;
		// Hold and enable together
		write_cfg(3'b101);
		run_frames(1'b0, 10);
		run_frames(1'b1, 10);
		check_view(held_time, held_tx, held_rx);
		write_cfg(3'b001);
		check_view(exp_time, exp_tx, exp_rx);
	endtask

	task automatic test_soft_reset();
		write_cfg(3'b011);
		exp_tx = '0;
		exp_rx = '0;
		exp_time = '0;
		check_view(exp_time, exp_tx, exp_rx);
		write_cfg(3'b001);
		check_view(exp_time, exp_tx, exp_rx);
		run_frames(1'b0, 8);
		run_frames(1'b1, 8);
		check_view(exp_time, exp_tx, exp_rx);
	endtask

	initial begin
		rst_n = 1'b0;
		wr_en = 1'b0;
		rd_en = 1'b0;
		addr = '0;
		wr_data = '0;
		tx_stats_vector = '0;
		tx_stats_valid = 1'b0;
		rx_stats_vector = '0;
		rx_stats_valid = 1'b0;
		// Start close to a carry so the high time word is exercised
		current_time = 64'h0000_00a5_ffff_ff00;
		time_running = 1'b1;
		exp_cfg = '0;
		exp_tx = '0;
		exp_rx = '0;
		exp_time = '0;
		lfsr_state = 32'hd124;
		errors = 0;
		checks = 0;

		repeat (5) @(posedge clk);
		#2;
		rst_n = 1'b1;

		test_reset_values();
		test_tx_counting();
		test_rx_counting();
		test_gated_frames();
		test_hold_snapshot();
		test_soft_reset();
		finish_run();
	end

endmodule

//--- hw/eth_stats_adder.sv
// ######################################
// Ethernet statistics adder
// Accumulates byte, good frame and bad
// frame counts from one vector stream
// ######################################

`timescale 1ns/1ps

module eth_stats_adder (
	input  logic                          clk,
	input  logic                          rst_n,
	input  logic                          clear,
	input  logic                          count_en,
	input  logic                          valid,
	input  logic [eth_stats_pkg::LEN_W-1:0] frame_length,
	input  logic                          frame_good,
	output eth_stats_pkg::stats_totals_t  totals,
	output logic                          update
);
	import eth_stats_pkg::*;

	// A frame counts only when the collector is enabled and the timer runs
	logic count_frame;

	assign count_frame = valid & count_en;

	// Counters and the update pulse share one synchronous process
	// Software reset clears the totals exactly like the hardware reset does
	always_ff @(posedge clk) begin
		if (!rst_n || clear) begin
			totals <= '0;
			update <= 1'b0;
		end else begin
			// The pulse lasts a single cycle unless another frame is counted
			update <= count_frame;

			if (count_frame) begin
				// Every frame adds its length, whether or not it was good
				totals.bytes <= totals.bytes + CNT_W'(frame_length);

				// Bit 0 of the vector tells a good frame from a bad one
				if (frame_good) begin
					totals.good <= totals.good + 1'b1;
				end else begin
					totals.bad <= totals.bad + 1'b1;
				end
			end
		end
	end

endmodule

//--- hw/eth_stats_collector.sv
// ######################################
// Ethernet statistics collector
// Counts MAC tx and rx traffic, stamps the
// last change and serves it to the host
// ######################################

`timescale 1ns/1ps

module eth_stats_collector (
	input  logic                           clk,
	input  logic                           rst_n,

	// Host register port
	input  logic                           wr_en,
	input  logic                           rd_en,
	input  logic [eth_stats_pkg::ADDR_W-1:0] addr,
	input  logic [eth_stats_pkg::DATA_W-1:0] wr_data,
	output logic [eth_stats_pkg::DATA_W-1:0] rd_data,
	output logic                           rd_valid,

	// Statistics vectors from the MAC, both on clk
	input  eth_stats_pkg::tx_stats_t       tx_stats_vector,
	input  logic                           tx_stats_valid,
	input  eth_stats_pkg::rx_stats_t       rx_stats_vector,
	input  logic                           rx_stats_valid,

	// Free running reference timer
	input  logic [63:0]                    current_time,
	input  logic                           time_running
);
	import eth_stats_pkg::*;

	cfg_t          cfg;
	logic          count_en;
	stats_totals_t tx_totals;
	stats_totals_t rx_totals;
	logic          tx_update;
	logic          rx_update;
	stats_record_t view;

	// Host access and configuration
	eth_stats_regs i_regs (
		.clk          (clk),
		.rst_n        (rst_n),
		.wr_en        (wr_en),
		.rd_en        (rd_en),
		.addr         (addr),
		.wr_data      (wr_data),
		.rd_data      (rd_data),
		.rd_valid     (rd_valid),
		.time_running (time_running),
		.view         (view),
		.cfg          (cfg),
		.count_en     (count_en)
	);

	// Transmit direction counters
	eth_stats_adder i_tx_adder (
		.clk          (clk),
		.rst_n        (rst_n),
		.clear        (cfg.srst),
		.count_en     (count_en),
		.valid        (tx_stats_valid),
		.frame_length (tx_stats_vector.frame_length),
		.frame_good   (tx_stats_vector.frame_good),
		.totals       (tx_totals),
		.update       (tx_update)
	);

	// Receive direction counters
	eth_stats_adder i_rx_adder (
		.clk          (clk),
		.rst_n        (rst_n),
		.clear        (cfg.srst),
		.count_en     (count_en),
		.valid        (rx_stats_valid),
		.frame_length (rx_stats_vector.frame_length),
		.frame_good   (rx_stats_vector.frame_good),
		.totals       (rx_totals),
		.update       (rx_update)
	);

	// Time stamp and hold snapshot
	eth_stats_snapshot i_snapshot (
		.clk          (clk),
		.rst_n        (rst_n),
		.clear        (cfg.srst),
		.hold         (cfg.hold),
		.current_time (current_time),
		.tx_totals    (tx_totals),
		.rx_totals    (rx_totals),
		.tx_update    (tx_update),
		.rx_update    (rx_update),
		.view         (view)
	);

endmodule

//--- hw/eth_stats_pkg.sv
// ######################################
// Ethernet statistics collector package
// Vector layouts, counter records and the
// host register map shared by all blocks
// ######################################

package eth_stats_pkg;

	// Counter and time stamp width
	localparam int CNT_W = 64;
	// Frame length field width in both MAC vectors
	localparam int LEN_W = 14;
	// Host port byte address and data widths
	localparam int ADDR_W = 8;
	localparam int DATA_W = 32;

	// Host register offsets in bytes
	// Offsets 0x04 to 0x0C are unmapped and read as zero
	localparam logic [ADDR_W-1:0] REG_CFG        = 8'h00;
	localparam logic [ADDR_W-1:0] REG_TIME_L     = 8'h10;
	localparam logic [ADDR_W-1:0] REG_TIME_H     = 8'h14;
	localparam logic [ADDR_W-1:0] REG_TX_BYTES_L = 8'h18;
	localparam logic [ADDR_W-1:0] REG_TX_BYTES_H = 8'h1C;
	localparam logic [ADDR_W-1:0] REG_TX_GOOD_L  = 8'h20;
	localparam logic [ADDR_W-1:0] REG_TX_GOOD_H  = 8'h24;
	localparam logic [ADDR_W-1:0] REG_TX_BAD_L   = 8'h28;
	localparam logic [ADDR_W-1:0] REG_TX_BAD_H   = 8'h2C;
	localparam logic [ADDR_W-1:0] REG_RX_BYTES_L = 8'h30;
	localparam logic [ADDR_W-1:0] REG_RX_BYTES_H = 8'h34;
	localparam logic [ADDR_W-1:0] REG_RX_GOOD_L  = 8'h38;
	localparam logic [ADDR_W-1:0] REG_RX_GOOD_H  = 8'h3C;
	localparam logic [ADDR_W-1:0] REG_RX_BAD_L   = 8'h40;
	localparam logic [ADDR_W-1:0] REG_RX_BAD_H   = 8'h44;

	// Transmit statistics vector as delivered by the MAC
	typedef struct packed {
		logic [12:0]      rsvd_hi;
		logic [LEN_W-1:0] frame_length;
		logic [3:0]       rsvd_mid;
		logic             frame_good;
	} tx_stats_t;

	// Receive vector, same low fields with a shorter upper part
	typedef struct packed {
		logic [8:0]       rsvd_hi;
		logic [LEN_W-1:0] frame_length;
		logic [3:0]       rsvd_mid;
		logic             frame_good;
	} rx_stats_t;

	// Running totals kept for one direction
	typedef struct packed {
		logic [CNT_W-1:0] bytes;
		logic [CNT_W-1:0] good;
		logic [CNT_W-1:0] bad;
	} stats_totals_t;

	// Everything the host can read besides the configuration
	typedef struct packed {
		logic [CNT_W-1:0] time_stamp;
		stats_totals_t    tx;
		stats_totals_t    rx;
	} stats_record_t;

	// Configuration register, enable sits in bit 0
	typedef struct packed {
		logic hold;
		logic srst;
		logic enable;
	} cfg_t;

endpackage

//--- hw/eth_stats_regs.sv
// ######################################
// Ethernet statistics register block
// Decodes host accesses, keeps the config
// and returns counter halves on reads
// ######################################

`timescale 1ns/1ps

module eth_stats_regs (
	input  logic                           clk,
	input  logic                           rst_n,
	input  logic                           wr_en,
	input  logic                           rd_en,
	input  logic [eth_stats_pkg::ADDR_W-1:0] addr,
	input  logic [eth_stats_pkg::DATA_W-1:0] wr_data,
	output logic [eth_stats_pkg::DATA_W-1:0] rd_data,
	output logic                           rd_valid,
	input  logic                           time_running,
	input  eth_stats_pkg::stats_record_t   view,
	output eth_stats_pkg::cfg_t            cfg,
	output logic                           count_en
);
	import eth_stats_pkg::*;

	// Read data selected from the current address before it is registered
	logic [DATA_W-1:0] rd_word;

	// Configuration register
	// Only REG_CFG is writable, the rest of the map is read only
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			cfg <= '0;
		end else if (wr_en && addr == REG_CFG) begin
			cfg <= cfg_t'(wr_data[$bits(cfg_t)-1:0]);
		end
	end

	// Collection runs only while enabled and while the reference timer runs
	assign count_en = cfg.enable & time_running;

	// Read decode
	// Each 64-bit value is split into a low and a high word at
	// consecutive offsets, the low word first
	always_comb begin
		case (addr)
			REG_CFG:        rd_word = DATA_W'(cfg);
			REG_TIME_L:     rd_word = view.time_stamp[DATA_W-1:0];
			REG_TIME_H:     rd_word = view.time_stamp[CNT_W-1:DATA_W];
			REG_TX_BYTES_L: rd_word = view.tx.bytes[DATA_W-1:0];
			REG_TX_BYTES_H: rd_word = view.tx.bytes[CNT_W-1:DATA_W];
			REG_TX_GOOD_L:  rd_word = view.tx.good[DATA_W-1:0];
			REG_TX_GOOD_H:  rd_word = view.tx.good[CNT_W-1:DATA_W];
			REG_TX_BAD_L:   rd_word = view.tx.bad[DATA_W-1:0];
			REG_TX_BAD_H:   rd_word = view.tx.bad[CNT_W-1:DATA_W];
			REG_RX_BYTES_L: rd_word = view.rx.bytes[DATA_W-1:0];
			REG_RX_BYTES_H: rd_word = view.rx.bytes[CNT_W-1:DATA_W];
			REG_RX_GOOD_L:  rd_word = view.rx.good[DATA_W-1:0];
			REG_RX_GOOD_H:  rd_word = view.rx.good[CNT_W-1:DATA_W];
			REG_RX_BAD_L:   rd_word = view.rx.bad[DATA_W-1:0];
			REG_RX_BAD_H:   rd_word = view.rx.bad[CNT_W-1:DATA_W];
			// The old FIFO registers and any unaligned offset end up here
			default:        rd_word = '0;
		endcase
	end

	// Read response
	// The strobe is answered exactly one cycle later and never stalls
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			rd_valid <= 1'b0;
		end else begin
			rd_valid <= rd_en;
		end
	end

	// Read data only changes on a read, so it stays stable after the answer
	always_ff @(posedge clk) begin
		if (rd_en) begin
			rd_data <= rd_word;
		end
	end

endmodule

//--- hw/eth_stats_snapshot.sv
// ######################################
// Ethernet statistics snapshot
// Builds the time stamped live record and
// freezes the host view while hold is set
// ######################################

`timescale 1ns/1ps

module eth_stats_snapshot (
	input  logic                          clk,
	input  logic                          rst_n,
	input  logic                          clear,
	input  logic                          hold,
	input  logic [63:0]                   current_time,
	input  eth_stats_pkg::stats_totals_t  tx_totals,
	input  eth_stats_pkg::stats_totals_t  rx_totals,
	input  logic                          tx_update,
	input  logic                          rx_update,
	output eth_stats_pkg::stats_record_t  view
);
	import eth_stats_pkg::*;

	// Timer value from the cycle in which the adders sampled the frame
	logic [CNT_W-1:0] time_d;
	// Record that tracks the counters with a one cycle delay
	stats_record_t    live_q;
	// Copy held for the host while hold is set
	stats_record_t    frozen_q;

	// The update pulses arrive one cycle after the frame was sampled,
	// so the timer has to be delayed by the same amount
	always_ff @(posedge clk) begin
		time_d <= current_time;
	end

	// Live record, cleared by either reset
	always_ff @(posedge clk) begin
		if (!rst_n || clear) begin
			live_q <= '0;
		end else begin
			// Totals are copied every cycle and only the stamp waits for a change
			live_q.tx <= tx_totals;
			live_q.rx <= rx_totals;

			if (tx_update || rx_update) begin
				live_q.time_stamp <= time_d;
			end
		end
	end

	// The frozen copy follows the live record until hold is seen high
	// Software reset clears it too, so a held view also reads zero
	always_ff @(posedge clk) begin
		if (!rst_n || clear) begin
			frozen_q <= '0;
		end else if (!hold) begin
			frozen_q <= live_q;
		end
	end

	// With hold low the host sees the live record directly, which keeps
	// the read path free of an extra cycle of delay
	assign view = hold ? frozen_q : live_q;

endmodule
